// ==== design/pic_macros.svh ====
`ifndef PIC_MACROS_SVH
`define PIC_MACROS_SVH

// Request lines served by one controller
`define PIC_NUM_IRQ 8

// Bits needed to name one request level
`define PIC_LEVEL_W 3

// CPU data bus
`define PIC_DATA_W 8

// Vector base is what remains of the data byte above the level
`define PIC_BASE_W (`PIC_DATA_W - `PIC_LEVEL_W)

`endif

// ==== design/pic_cmd_pkg.sv ====
`default_nettype none

`include "pic_macros.svh"

package pic_cmd_pkg;

	// OCW2 command codes that this controller acts on
	localparam logic [2:0] OCW2_NS_EOI = 3'b001;
	localparam logic [2:0] OCW2_SP_EOI = 3'b011;

	// One CPU write, valid for the single cycle wr is high
	typedef struct packed
	{
		logic                   wr;
		logic                   a0;
		logic [`PIC_DATA_W-1:0] data;
	} cpu_write_t;

	typedef struct packed
	{
		logic [2:0] vec_addr;
		logic       marker;
		logic       ltim;
		logic       adi;
		logic       single;
		logic       ic4;
	} icw1_t;

	typedef struct packed
	{
		logic [2:0]              cmd;
		logic [1:0]              sel;
		logic [`PIC_LEVEL_W-1:0] level;
	} ocw2_t;

	typedef struct packed
	{
		logic       spare;
		logic [1:0] smm;
		logic       icw1_bit;
		logic       marker;
		logic       poll;
		logic       read_en;
		logic       read_isr;
	} ocw3_t;

	// Same A0=0 byte seen three ways
	typedef union packed
	{
		icw1_t icw1;
		ocw2_t ocw2;
		ocw3_t ocw3;
	} command_word_u;

endpackage

`default_nettype wire

// ==== design/pic_ctl_pkg.sv ====
`default_nettype none

`include "pic_macros.svh"

package pic_ctl_pkg;

	// Programmed state, vector base from ICW2 bits 7..3
	typedef struct packed
	{
		logic                    ltim;
		logic [`PIC_BASE_W-1:0]  vector_base;
		logic [`PIC_NUM_IRQ-1:0] mask;
	} pic_config_t;

	// End of interrupt, one cycle
	typedef struct packed
	{
		logic                    valid;
		logic                    specific;
		logic [`PIC_LEVEL_W-1:0] level;
	} eoi_cmd_t;

	// Winner of the priority resolver
	typedef struct packed
	{
		logic                    valid;
		logic [`PIC_LEVEL_W-1:0] level;
	} service_req_t;

	// Moves one level from IRR to ISR
	typedef struct packed
	{
		logic                    latch;
		logic [`PIC_LEVEL_W-1:0] level;
	} ack_pulse_t;

endpackage

`default_nettype wire

// ==== design/pic_command_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pic_command_regs (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire pic_cmd_pkg::cpu_write_t cpu_wr,
	output pic_ctl_pkg::pic_config_t     cfg,
	output logic                         read_isr,
	output pic_ctl_pkg::eoi_cmd_t        eoi,
	output logic                         poll_req,
	output logic                         init_clear
);

	typedef enum logic [1:0]
	{
		PROG_NONE,
		PROG_ICW2,
		PROG_READY
	} prog_state_t;

	prog_state_t                state;
	pic_cmd_pkg::command_word_u cmd;
	logic                       wr_cmd;
	logic                       wr_data;
	logic                       ready;
	logic                       is_icw1;
	logic                       is_ocw2;
	logic                       is_ocw3;

	assign cmd     = cpu_wr.data;
	assign wr_cmd  = cpu_wr.wr & ~cpu_wr.a0;
	assign wr_data = cpu_wr.wr & cpu_wr.a0;
	assign ready   = (state == PROG_READY);

	// ICW1 restarts programming from any state
	assign is_icw1 = wr_cmd & cmd.icw1.marker;
	assign is_ocw2 = wr_cmd & ready & (cmd.ocw2.sel == 2'b00);
	assign is_ocw3 = wr_cmd & ready & ~cmd.ocw3.icw1_bit & cmd.ocw3.marker;

	assign init_clear = is_icw1;
	assign poll_req   = is_ocw3 & cmd.ocw3.poll;

	assign eoi.valid    = is_ocw2 & ((cmd.ocw2.cmd == pic_cmd_pkg::OCW2_NS_EOI) |
		(cmd.ocw2.cmd == pic_cmd_pkg::OCW2_SP_EOI));
	assign eoi.specific = (cmd.ocw2.cmd == pic_cmd_pkg::OCW2_SP_EOI);
	assign eoi.level    = cmd.ocw2.level;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state    <= PROG_NONE;
			cfg      <= '0;
			read_isr <= 1'b0;
		end
		else if (is_icw1)
		begin
			// SNGL and IC4 are accepted but ignored
			state    <= PROG_ICW2;
			cfg.ltim <= cmd.icw1.ltim;
			cfg.mask <= '0;
			read_isr <= 1'b0;
		end
		else if (wr_data && state == PROG_ICW2)
		begin
			cfg.vector_base <= cpu_wr.data[7:3];
			state           <= PROG_READY;
		end
		else if (wr_data && ready)
		begin
			cfg.mask <= cpu_wr.data;
		end
		else if (is_ocw3 && cmd.ocw3.read_en)
		begin
			read_isr <= cmd.ocw3.read_isr;
		end
	end

endmodule

`default_nettype wire

// ==== design/pic_request_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_macros.svh"

module pic_request_latch (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire [`PIC_NUM_IRQ-1:0]       ir,
	input  wire                          ltim,
	input  wire                          init_clear,
	input  wire pic_ctl_pkg::ack_pulse_t ack,
	output logic [`PIC_NUM_IRQ-1:0]      irr
);

	logic [`PIC_NUM_IRQ-1:0] ir_q;
	logic [`PIC_NUM_IRQ-1:0] rise;
	logic [`PIC_NUM_IRQ-1:0] set_req;
	logic [`PIC_NUM_IRQ-1:0] ack_bit;

	assign rise    = ir & ~ir_q;
	assign ack_bit = `PIC_NUM_IRQ'(ack.latch) << ack.level;

	// Level mode follows the line, edge mode needs a fresh rise
	assign set_req = ltim ? ir : rise;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			ir_q <= '0;
			irr  <= '0;
		end
		else
		begin
			ir_q <= ir;
			if (init_clear)
			begin
				irr <= '0;
			end
			else
			begin
				// Held bits drop when the line falls
				irr <= (set_req | (irr & ir)) & ~ack_bit;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/pic_service_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_macros.svh"

module pic_service_unit (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire [`PIC_NUM_IRQ-1:0]       irr,
	input  wire [`PIC_NUM_IRQ-1:0]       mask,
	input  wire pic_ctl_pkg::ack_pulse_t ack,
	input  wire pic_ctl_pkg::eoi_cmd_t   eoi,
	input  wire                          init_clear,
	output pic_ctl_pkg::service_req_t    request,
	output logic [`PIC_NUM_IRQ-1:0]      isr
);

	logic [`PIC_NUM_IRQ-1:0] pending;
	logic [`PIC_NUM_IRQ-1:0] ack_bit;
	logic [`PIC_NUM_IRQ-1:0] lowest_isr;
	logic [`PIC_NUM_IRQ-1:0] eoi_bit;

	assign pending = irr & ~mask;
	assign ack_bit = `PIC_NUM_IRQ'(ack.latch) << ack.level;

	// Lowest set bit is the highest priority in service
	assign lowest_isr = isr & (~isr + `PIC_NUM_IRQ'(1));

	always_comb
	begin
		if (!eoi.valid)
			eoi_bit = '0;
		else if (eoi.specific)
			eoi_bit = `PIC_NUM_IRQ'(1) << eoi.level;
		else
			eoi_bit = lowest_isr;
	end

	// Fixed priority with IR0 highest, stopping at the first level in service
	always_comb
	begin : resolve
		logic blocked;
		blocked = 1'b0;
		request = '0;
		for (int i = 0; i < `PIC_NUM_IRQ; i++)
		begin
			if (isr[i])
				blocked = 1'b1;
			if (pending[i] && !blocked && !request.valid)
			begin
				request.valid = 1'b1;
				request.level = `PIC_LEVEL_W'(i);
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			isr <= '0;
		end
		else if (init_clear)
		begin
			isr <= '0;
		end
		else
		begin
			isr <= (isr | ack_bit) & ~eoi_bit;
		end
	end

endmodule

`default_nettype wire

// ==== design/pic_ack_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_macros.svh"

module pic_ack_sequencer (
	input  wire                            clock,
	input  wire                            rst_n,
	input  wire                            inta_n,
	input  wire                            rd,
	input  wire                            rd_a0,
	input  wire                            poll_req,
	input  wire pic_ctl_pkg::service_req_t request,
	input  wire pic_ctl_pkg::pic_config_t  cfg,
	input  wire                            read_isr,
	input  wire [`PIC_NUM_IRQ-1:0]         irr,
	input  wire [`PIC_NUM_IRQ-1:0]         isr,
	output pic_ctl_pkg::ack_pulse_t        ack,
	output logic                           int_out,
	output logic [`PIC_DATA_W-1:0]         vector,
	output logic                           vector_oe,
	output logic [`PIC_DATA_W-1:0]         rdata,
	output logic                           rdata_valid
);

	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_FIRST,
		SEQ_VECTOR,
		SEQ_POLL
	} seq_state_t;

	seq_state_t              state;
	logic                    inta_q;
	logic                    inta_fall;
	logic                    start_ack;
	logic                    poll_read;
	logic                    seq_end;
	logic [`PIC_LEVEL_W-1:0] level_q;

	assign inta_fall = inta_q & ~inta_n;
	assign start_ack = (state == SEQ_IDLE) & inta_fall;
	assign poll_read = (state == SEQ_POLL) & rd;
	assign seq_end   = (state == SEQ_VECTOR) & inta_n;

	assign ack.latch = (start_ack | poll_read) & request.valid;
	assign ack.level = request.level;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state       <= SEQ_IDLE;
			inta_q      <= 1'b1;
			int_out     <= 1'b0;
			vector_oe   <= 1'b0;
			rdata_valid <= 1'b0;
		end
		else
		begin
			inta_q      <= inta_n;
			rdata_valid <= rd;
			case (state)
				SEQ_IDLE:
					if (inta_fall)
						state <= SEQ_FIRST;
					else if (poll_req)
						state <= SEQ_POLL;
				SEQ_FIRST:
					if (inta_fall)
					begin
						state     <= SEQ_VECTOR;
						vector_oe <= 1'b1;
					end
				SEQ_VECTOR:
					if (inta_n)
					begin
						state     <= SEQ_IDLE;
						vector_oe <= 1'b0;
					end
				SEQ_POLL:
					if (rd)
						state <= SEQ_IDLE;
			endcase
			// Held through the sequence, follows the resolver when idle
			if (seq_end || poll_read)
				int_out <= 1'b0;
			else if (state == SEQ_IDLE)
				int_out <= request.valid;
		end
	end

	always_ff @(posedge clock)
	begin
		// Spurious acknowledge reports level 7
		if (start_ack)
			level_q <= request.valid ? request.level : '1;
		if (state == SEQ_FIRST && inta_fall)
			vector <= {cfg.vector_base, level_q};
		if (poll_read)
			rdata <= request.valid ?
				{1'b1, {(`PIC_DATA_W - `PIC_LEVEL_W - 1){1'b0}}, request.level} : '0;
		else if (rd)
			rdata <= rd_a0 ? cfg.mask : (read_isr ? isr : irr);
	end

endmodule

`default_nettype wire

// ==== design/pic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_macros.svh"

module pic_top (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire pic_cmd_pkg::cpu_write_t cpu_wr,
	input  wire                          rd,
	input  wire                          rd_a0,
	input  wire                          inta_n,
	input  wire [`PIC_NUM_IRQ-1:0]       ir,
	output logic                         int_out,
	output logic [`PIC_DATA_W-1:0]       vector,
	output logic                         vector_oe,
	output logic [`PIC_DATA_W-1:0]       rdata,
	output logic                         rdata_valid
);

	pic_ctl_pkg::pic_config_t  cfg;
	pic_ctl_pkg::eoi_cmd_t     eoi;
	pic_ctl_pkg::service_req_t request;
	pic_ctl_pkg::ack_pulse_t   ack;
	logic                      read_isr;
	logic                      poll_req;
	logic                      init_clear;
	logic [`PIC_NUM_IRQ-1:0]   irr;
	logic [`PIC_NUM_IRQ-1:0]   isr;

	pic_command_regs command_regs_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.cpu_wr     (cpu_wr),
		.cfg        (cfg),
		.read_isr   (read_isr),
		.eoi        (eoi),
		.poll_req   (poll_req),
		.init_clear (init_clear)
	);

	pic_request_latch request_latch_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.ir         (ir),
		.ltim       (cfg.ltim),
		.init_clear (init_clear),
		.ack        (ack),
		.irr        (irr)
	);

	pic_service_unit service_unit_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.irr        (irr),
		.mask       (cfg.mask),
		.ack        (ack),
		.eoi        (eoi),
		.init_clear (init_clear),
		.request    (request),
		.isr        (isr)
	);

	pic_ack_sequencer ack_sequencer_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.inta_n      (inta_n),
		.rd          (rd),
		.rd_a0       (rd_a0),
		.poll_req    (poll_req),
		.request     (request),
		.cfg         (cfg),
		.read_isr    (read_isr),
		.irr         (irr),
		.isr         (isr),
		.ack         (ack),
		.int_out     (int_out),
		.vector      (vector),
		.vector_oe   (vector_oe),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/pic_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pic_sva (
	input wire clock,
	input wire rst_n,
	input wire int_out,
	input wire vector_oe,
	input wire rdata_valid
);

	// Outputs quiet once reset has been seen
	reset_quiet: assert property (@(posedge clock) !rst_n |=> (!int_out && !vector_oe))
		else $error("int_out or vector_oe high after reset");

	// Vector and register read never overlap
	no_bus_clash: assert property (@(posedge clock) disable iff (!rst_n)
		!(vector_oe && rdata_valid))
		else $error("vector_oe and rdata_valid high together");

	read_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		rdata_valid |=> !rdata_valid)
		else $error("rdata_valid longer than one cycle");

endmodule

bind pic_top pic_sva sva_i (.*);

`default_nettype wire

// ==== testbench/pic_tests.svh ====
`ifndef PIC_TESTS_SVH
`define PIC_TESTS_SVH

task automatic test_program_and_read();
	logic [31:0] r;
	logic [7:0] mask_v;
	logic [7:0] ir_v;
	logic [7:0] d;
	r = next_random();
	mask_v = r[7:0];
	base_byte = r[15:8] & 8'hF8;
	ir_v = r[23:16];
	write_reg(1'b0, 8'h1B);
	write_reg(1'b1, base_byte);
	write_reg(1'b1, mask_v);
	read_reg(1'b1, d);
	check_data("rdata mask", d, mask_v);
	set_ir(ir_v);
	idle_cycles(3);
	write_reg(1'b0, 8'h0A);
	read_reg(1'b0, d);
	check_data("rdata irr", d, ir_v);
	set_ir(8'h00);
	finish_test("program and read");
endtask

task automatic test_inta_vector();
	logic [7:0] vec;
	logic [7:0] d;
	write_reg(1'b1, 8'h00);
	set_ir(8'h28);
	wait_int(1'b1);
	run_inta(vec);
	check_data("vector", vec, base_byte | 8'd3);
	check_level("vector level", vec[2:0], 3'd3);
	idle_cycles(3);
	check_int(1'b0);
	write_reg(1'b0, 8'h0B);
	read_reg(1'b0, d);
	check_data("rdata isr", d, 8'h08);
	finish_test("inta vector");
endtask

task automatic test_mask_and_nesting();
	logic [7:0] vec;
	// IR1 is masked and IR6 sits below the level in service
	write_reg(1'b1, 8'h02);
	set_ir(8'h4A);
	idle_cycles(8);
	check_int(1'b0);
	write_reg(1'b1, 8'h00);
	wait_int(1'b1);
	run_inta(vec);
	check_data("vector", vec, base_byte | 8'd1);
	set_ir(8'h00);
	finish_test("mask and nesting");
endtask

task automatic test_eoi();
	logic [7:0] d;
	read_reg(1'b0, d);
	check_data("rdata isr", d, 8'h0A);
	// Level 3 is not the lowest bit in service
	write_reg(1'b0, 8'h63);
	read_reg(1'b0, d);
	check_data("rdata isr", d, 8'h02);
	write_reg(1'b0, 8'h20);
	read_reg(1'b0, d);
	check_data("rdata isr", d, 8'h00);
	finish_test("eoi");
endtask

task automatic test_poll();
	logic [31:0] r;
	logic [7:0] ir_v;
	logic [2:0] lvl;
	logic [7:0] d;
	r = next_random();
	ir_v = r[7:0];
	if (ir_v == 8'h00)
		ir_v = 8'h40;
	lvl = lowest_level(ir_v);
	set_ir(ir_v);
	idle_cycles(3);
	write_reg(1'b0, 8'h0C);
	read_reg(1'b0, d);
	check_data("rdata poll", d, 8'h80 | {5'd0, lvl});
	check_level("poll level", d[2:0], lvl);
	write_reg(1'b0, 8'h0B);
	read_reg(1'b0, d);
	check_data("rdata isr", d, 8'h01 << lvl);
	write_reg(1'b0, {5'b01100, lvl});
	set_ir(8'h00);
	idle_cycles(3);
	write_reg(1'b0, 8'h0C);
	read_reg(1'b0, d);
	check_data("rdata poll", d, 8'h00);
	finish_test("poll");
endtask

task automatic test_edge_vs_level();
	logic [7:0] vec;
	logic [7:0] d;
	write_reg(1'b0, 8'h13);
	write_reg(1'b1, base_byte);
	set_ir(8'h04);
	wait_int(1'b1);
	run_inta(vec);
	check_data("vector", vec, base_byte | 8'd2);
	write_reg(1'b0, 8'h20);
	// Edge mode gives no new request while the line stays high
	idle_cycles(6);
	check_int(1'b0);
	write_reg(1'b0, 8'h0A);
	read_reg(1'b0, d);
	check_data("rdata irr", d, 8'h00);
	set_ir(8'h00);
	idle_cycles(2);
	set_ir(8'h04);
	wait_int(1'b1);
	run_inta(vec);
	check_data("vector", vec, base_byte | 8'd2);
	write_reg(1'b0, 8'h20);
	write_reg(1'b0, 8'h1B);
	write_reg(1'b1, base_byte);
	wait_int(1'b1);
	run_inta(vec);
	check_data("vector", vec, base_byte | 8'd2);
	write_reg(1'b0, 8'h20);
	wait_int(1'b1);
	set_ir(8'h00);
	finish_test("edge vs level");
endtask

`endif

// ==== testbench/pic_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_macros.svh"

module pic_tb;

	localparam int NUM_TESTS = 6;

	logic                          clock;
	logic                          rst_n;
	pic_cmd_pkg::cpu_write_t       cpu_wr;
	logic                          rd;
	logic                          rd_a0;
	logic                          inta_n;
	logic [`PIC_NUM_IRQ-1:0]       ir;
	logic                          int_out;
	logic [`PIC_DATA_W-1:0]        vector;
	logic                          vector_oe;
	logic [`PIC_DATA_W-1:0]        rdata;
	logic                          rdata_valid;

	logic [31:0] rng_state = 32'h5c33c605;
	logic [7:0]  base_byte;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_done = 0;

	pic_top pic_top_i (.*);

	initial
	begin
		clock = 1'b0;
		rst_n = 1'b0;
		cpu_wr = '0;
		rd = 1'b0;
		rd_a0 = 1'b0;
		inta_n = 1'b1;
		ir = '0;
		base_byte = 8'h00;
	end

	always #10 clock = ~clock;

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	// Fixed priority with IR0 first
	function automatic logic [`PIC_LEVEL_W-1:0] lowest_level(input logic [7:0] bits);
		logic [`PIC_LEVEL_W-1:0] lvl;
		lvl = '1;
		for (int i = `PIC_NUM_IRQ - 1; i >= 0; i--)
			if (bits[i])
				lvl = `PIC_LEVEL_W'(i);
		return lvl;
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_data(input string name, input logic [`PIC_DATA_W-1:0] got,
		input logic [`PIC_DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_level(input string name, input logic [`PIC_LEVEL_W-1:0] got,
		input logic [`PIC_LEVEL_W-1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_int(input logic exp);
		if (int_out !== exp)
		begin
			$display("FAIL int_out got 0x%h expected 0x%h", int_out, exp);
			note_error();
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic set_ir(input logic [7:0] v);
		@(posedge clock);
		ir <= v;
	endtask

	task automatic write_reg(input logic a0, input logic [7:0] d);
		@(posedge clock);
		cpu_wr <= '{wr: 1'b1, a0: a0, data: d};
		@(posedge clock);
		cpu_wr <= '0;
	endtask

	task automatic read_reg(input logic a0, output logic [7:0] d);
		int n;
		@(posedge clock);
		rd <= 1'b1;
		rd_a0 <= a0;
		@(posedge clock);
		rd <= 1'b0;
		n = 0;
		@(negedge clock);
		while (!rdata_valid && n < 20)
		begin
			@(negedge clock);
			n++;
		end
		if (!rdata_valid)
		begin
			$display("Read got no rdata_valid within 20 cycles");
			note_error();
		end
		d = rdata;
	endtask

	task automatic wait_int(input logic exp);
		int n;
		n = 0;
		@(negedge clock);
		while (int_out !== exp && n < 50)
		begin
			@(negedge clock);
			n++;
		end
		if (int_out !== exp)
		begin
			$display("int_out did not reach %0d within 50 cycles", exp);
			note_error();
		end
	endtask

	// Two INTA pulses and the vector seen while vector_oe is high
	task automatic run_inta(output logic [7:0] vec);
		int n;
		@(posedge clock);
		inta_n <= 1'b0;
		@(posedge clock);
		inta_n <= 1'b1;
		@(posedge clock);
		inta_n <= 1'b0;
		n = 0;
		@(negedge clock);
		while (!vector_oe && n < 20)
		begin
			@(negedge clock);
			n++;
		end
		if (!vector_oe)
		begin
			$display("vector_oe never rose after the second INTA pulse");
			note_error();
		end
		vec = vector;
		@(posedge clock);
		inta_n <= 1'b1;
		n = 0;
		@(negedge clock);
		while (vector_oe && n < 20)
		begin
			@(negedge clock);
			n++;
		end
		if (vector_oe)
		begin
			$display("vector_oe stayed high after INTA was released");
			note_error();
		end
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		if (test_errors == 0)
			$display("test %0d %s: ok", tests_done, name);
		else
			$display("test %0d %s: %0d errors", tests_done, name, test_errors);
		test_errors = 0;
	endtask

	`include "pic_tests.svh"

	initial
	begin
		repeat (2000 * NUM_TESTS) @(posedge clock);
		$display("Watchdog expired before the tests completed");
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		idle_cycles(2);
		test_program_and_read();
		test_inta_vector();
		test_mask_and_nesting();
		test_eoi();
		test_poll();
		test_edge_vs_level();
		idle_cycles(4);
		$display("%0d tests run, %0d errors", tests_done, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
+incdir+testbench
design/pic_cmd_pkg.sv
design/pic_ctl_pkg.sv
design/pic_command_regs.sv
design/pic_request_latch.sv
design/pic_service_unit.sv
design/pic_ack_sequencer.sv
design/pic_top.sv
testbench/pic_sva.sv
testbench/pic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pic_tb -f project.f -o pic_sim
./obj_dir/pic_sim | tee sim.log

if grep -q "TB PASSED" sim.log; then
	exit 0
else
	exit 1
fi
